// File: fas_delay_line.sv
`timescale 1ns/1ps

// Fixed-latency shift register for a bundle of select bits
module fas_delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk_FAS,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // Stage 0 is nearest din
    logic [DEPTH-1:0][WIDTH-1:0] stage;

    ////////////////////////////////////////////////////////////////////////////
    // Shift chain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '0;
        end else begin
            stage[0] <= din;
            // One stage per cycle
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // Oldest entry out
    assign dout = stage[DEPTH-1];

    // Zero depth would be a wire
    depth_min_a : assert property (@(posedge clk_FAS) DEPTH >= 1);

endmodule

// File: fas_issue_ctrl.sv
`timescale 1ns/1ps

`include "fas_params.svh"

module fas_issue_ctrl
    import fas_pkg::*;
(
    input  logic                       clk_FAS,
    input  logic                       rst_n,
    input  logic                       fas_rdy_n,
    input  fas_opcode_e                opcode,
    input  layer_state_e               layer_state,
    input  fifo_status_t               fifo_status,
    input  logic [`FAS_KRNL_CNT_W-1:0] krnl_count,
    input  logic                       dwc_fifo_rden,
    input  logic                       hold_off,
    output issue_strobe_t              strobes,
    output vadd_sel_t                  vadd_sel_pre,
    output logic                       rm1_pre,
    output post_sel_t                  post_sel_pre
);

    // One row of the issue table
    // A set bit in req means that FIFO must hold data
    typedef struct packed {
        logic          valid;
        fifo_status_t  req;
        issue_strobe_t strb;
        logic          pm;
        logic          rm0;
        logic          rm1;
        logic          krnl_gated;
    } op_row_t;

    op_row_t row;
    logic    issue_state;
    logic    fifo_ready;
    logic    krnl_zero;
    logic    issue;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        row = '0;
        case (opcode)
            op_conv_pm: begin
                row.valid          = 1'b1;
                row.req.conv_empty = 1'b1;
                row.req.part_empty = 1'b1;
                row.req.resd_empty = 1'b1;
                row.strb.start1    = 1'b1;
                // Partial map only joins on the first kernel
                row.pm             = 1'b1;
                row.krnl_gated     = 1'b1;
            end
            op_conv_rm: begin
                row.valid          = 1'b1;
                row.req.conv_empty = 1'b1;
                row.strb.start0    = 1'b1;
            end
            op_conv_pv: begin
                row.valid          = 1'b1;
                row.req.conv_empty = 1'b1;
                row.req.prev_empty = 1'b1;
                row.strb.start0    = 1'b1;
            end
            op_conv_pm_rm_pv: begin
                row.valid          = 1'b1;
                row.req            = '1;
                row.strb.start2    = 1'b1;
                row.pm             = 1'b1;
                row.rm1            = 1'b1;
                row.krnl_gated     = 1'b1;
            end
            op_pm_rm_add: begin
                row.valid          = 1'b1;
                row.req.conv_empty = 1'b1;
                row.req.part_empty = 1'b1;
                row.req.resd_empty = 1'b1;
                row.strb.wren2     = 1'b1;
                row.pm             = 1'b1;
                row.rm1            = 1'b1;
            end
            op_resd_add: begin
                row.valid          = 1'b1;
                row.req.conv_empty = 1'b1;
                row.req.resd_empty = 1'b1;
                row.strb.wren1     = 1'b1;
                row.rm0            = 1'b1;
            end
            op_part_add: begin
                row.valid          = 1'b1;
                row.req.conv_empty = 1'b1;
                row.req.part_empty = 1'b1;
                row.strb.wren1     = 1'b1;
                row.pm             = 1'b1;
            end
            // Unknown code never issues
            default: row = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue rule
    ////////////////////////////////////////////////////////////////////////////

    // Only these two layer states let vectors in
    assign issue_state = (layer_state == st_active) || (layer_state == st_wait_last_write);
    // No required FIFO may be empty
    assign fifo_ready  = ((fifo_status & row.req) == '0);
    assign krnl_zero   = (krnl_count == '0);
    // Delayed pipe enable blocks a new vector
    assign issue       = issue_state && !hold_off && row.valid && fifo_ready;

    // Strobes and pre-delay selects
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            strobes      <= '0;
            vadd_sel_pre <= '0;
            rm1_pre      <= 1'b0;
        end else if (fas_rdy_n || !issue) begin
            // Single-cycle pulses
            strobes      <= '0;
            vadd_sel_pre <= '0;
            rm1_pre      <= 1'b0;
        end else begin
            strobes                  <= row.strb;
            vadd_sel_pre.pipe_enable <= 1'b1;
            vadd_sel_pre.vadd_pm     <= row.pm && (krnl_zero || !row.krnl_gated);
            vadd_sel_pre.vadd_rm0    <= row.rm0;
            rm1_pre                  <= row.rm1 && (krnl_zero || !row.krnl_gated);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Down-conversion read stage
    ////////////////////////////////////////////////////////////////////////////

    // Residual conv or previous vector add per dwc FIFO read
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            post_sel_pre <= '0;
        end else if (fas_rdy_n) begin
            post_sel_pre <= '0;
        end else begin
            post_sel_pre.vadd_rm_conv <= dwc_fifo_rden
                && ((opcode == op_conv_pm) || (opcode == op_conv_rm));
            post_sel_pre.vadd_pv      <= dwc_fifo_rden
                && ((opcode == op_conv_pv) || (opcode == op_conv_pm_rm_pv));
        end
    end

    // Never two conv lanes at once
    one_start_a : assert property (@(posedge clk_FAS) disable iff (!rst_n)
        $onehot0({strobes.start0, strobes.start1, strobes.start2}));

    // Non-issuing layer state keeps next cycle quiet
    no_strobe_idle_a : assert property (@(posedge clk_FAS) disable iff (!rst_n)
        !(layer_state inside {st_active, st_wait_last_write}) |=> (strobes == '0));

endmodule

// File: fas_params.svh
`ifndef FAS_PARAMS_SVH
`define FAS_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Pipeline latencies of the feature-map datapath
////////////////////////////////////////////////////////////////////////////

// Read latency of the feature-map FIFOs in clk_FAS cycles
// Selects for the vector adder wait this long after the issue register
`define FAS_FIFO_LATENCY 3

// Latency through the vector adder in clk_FAS cycles
// The second residual add (rm1) sits behind two FIFO reads and one add
`define FAS_VEC_ADD_LATENCY 4

////////////////////////////////////////////////////////////////////////////
// Counter widths
////////////////////////////////////////////////////////////////////////////

// Width of the kernel counter from the layer FSM
// Zero marks the first kernel of a group
`define FAS_KRNL_CNT_W 16

`endif

// File: fas_pip_ctrl.sv
`timescale 1ns/1ps

`include "fas_params.svh"

module fas_pip_ctrl
    import fas_pkg::*;
(
    input  logic                       rst_n,
    input  logic                       clk_FAS,
    input  logic                       fas_rdy_n,
    input  fas_opcode_e                opcode,
    input  layer_state_e               layer_state,
    input  fifo_status_t               fifo_status,
    input  logic [`FAS_KRNL_CNT_W-1:0] krnl_count,
    input  logic                       dwc_fifo_rden,
    output issue_strobe_t              strobes,
    output vadd_sel_t                  vadd_sel,
    output logic                       vadd_rm1,
    output post_sel_t                  post_sel
);

    // rm1 waits for two FIFO reads and one vector add
    localparam int RM1_DEPTH = 2 * `FAS_FIFO_LATENCY + `FAS_VEC_ADD_LATENCY;

    vadd_sel_t vadd_sel_pre;
    logic      rm1_pre;
    post_sel_t post_sel_pre;

    ////////////////////////////////////////////////////////////////////////////
    // Issue controller
    ////////////////////////////////////////////////////////////////////////////

    // Delayed pipe enable comes back as hold-off
    fas_issue_ctrl u_issue_ctrl (
        .clk_FAS       (clk_FAS),
        .rst_n         (rst_n),
        .fas_rdy_n     (fas_rdy_n),
        .opcode        (opcode),
        .layer_state   (layer_state),
        .fifo_status   (fifo_status),
        .krnl_count    (krnl_count),
        .dwc_fifo_rden (dwc_fifo_rden),
        .hold_off      (vadd_sel.pipe_enable),
        .strobes       (strobes),
        .vadd_sel_pre  (vadd_sel_pre),
        .rm1_pre       (rm1_pre),
        .post_sel_pre  (post_sel_pre)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Alignment delays
    ////////////////////////////////////////////////////////////////////////////

    // Adder selects line up with FIFO read data
    fas_delay_line #(
        .WIDTH ($bits(vadd_sel_t)),
        .DEPTH (`FAS_FIFO_LATENCY)
    ) u_vadd_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .din     (vadd_sel_pre),
        .dout    (vadd_sel)
    );

    // Post-stage selects
    fas_delay_line #(
        .WIDTH ($bits(post_sel_t)),
        .DEPTH (`FAS_FIFO_LATENCY)
    ) u_post_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .din     (post_sel_pre),
        .dout    (post_sel)
    );

    // Second residual add
    fas_delay_line #(
        .WIDTH (1),
        .DEPTH (RM1_DEPTH)
    ) u_rm1_dly (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .din     (rm1_pre),
        .dout    (vadd_rm1)
    );

endmodule

// File: fas_pkg.sv
package fas_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Layer and opcode encodings
    ////////////////////////////////////////////////////////////////////////////

    // Layer FSM state as seen by the issue controller
    typedef enum logic [2:0] {
        st_idle             = 3'd0,
        st_ld_krnl          = 3'd1,
        st_ld_krnl_bias     = 3'd2,
        st_cfg              = 3'd3,
        st_start            = 3'd4,
        st_active           = 3'd5,
        st_wait_last_write  = 3'd6,
        st_send_complete    = 3'd7
    } layer_state_e;

    // Layer opcode, binary
    // Gaps in the numbering are opcodes that no longer exist
    typedef enum logic [3:0] {
        op_conv_pm          = 4'd0,
        op_conv_rm          = 4'd2,
        op_conv_pv          = 4'd3,
        op_conv_pm_rm_pv    = 4'd5,
        op_pm_rm_add        = 4'd8,
        op_resd_add         = 4'd9,
        op_part_add         = 4'd15
    } fas_opcode_e;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    // Empty flags of the four map FIFOs
    typedef struct packed {
        logic conv_empty;
        logic part_empty;
        logic resd_empty;
        logic prev_empty;
    } fifo_status_t;

    // Undelayed issue strobes
    // One conv lane start and the output buffer writes
    typedef struct packed {
        logic start0;
        logic start1;
        logic start2;
        logic wren1;
        logic wren2;
    } issue_strobe_t;

    // Selects aligned to the FIFO read data
    typedef struct packed {
        logic pipe_enable;
        logic vadd_pm;
        logic vadd_rm0;
    } vadd_sel_t;

    // Selects from the down-conversion FIFO read
    typedef struct packed {
        logic vadd_rm_conv;
        logic vadd_pv;
    } post_sel_t;

endpackage

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_fas_pip_ctrl -o sim_tb

# A failed assertion stops the model, the search below still decides
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+.
fas_pkg.sv
fas_delay_line.sv
fas_issue_ctrl.sv
fas_pip_ctrl.sv
tb_clk_gen.sv
tb_fas_pip_ctrl.sv

// File: tb_clk_gen.sv
`timescale 1ns/1ps

// Free-running clock for the testbench
module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_FAS
);

    // Starts low so the first edge is a rising one
    // Half period per toggle
    initial begin
        clk_FAS = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_FAS = ~clk_FAS;
        end
    end

endmodule

// File: tb_fas_pip_ctrl.sv
`timescale 1ns/1ps

`include "fas_params.svh"

module tb_fas_pip_ctrl
    import fas_pkg::*;
();

    localparam int CLK_PERIOD_NS = 8;
    localparam int RST_CYCLES    = 10;
    // Output window index counted from the sampling edge
    // Index 0 is the cycle right after it, so latency L lands at L-1
    localparam int VSEL_IDX      = `FAS_FIFO_LATENCY;
    localparam int RM1_IDX       = 2 * `FAS_FIFO_LATENCY + `FAS_VEC_ADD_LATENCY;
    localparam int OBS_LEN       = RM1_IDX + 2;
    localparam int POST_LEN      = VSEL_IDX + 2;
    localparam int GATE_ROUNDS   = 50;
    localparam int GATE_GAP      = 4;
    localparam int STREAM_CYCLES = 40;
    // Cycle budget of all tests, doubled for the watchdog
    localparam int RUN_CYCLES    = RST_CYCLES + 21 + 14 * OBS_LEN
                                 + GATE_ROUNDS * (GATE_GAP + 1) + STREAM_CYCLES + OBS_LEN
                                 + 7 * POST_LEN;
    localparam int TIMEOUT_NS    = 2 * RUN_CYCLES * CLK_PERIOD_NS + 200;

    // Expected result of one issue
    typedef struct packed {
        issue_strobe_t strb;
        logic          pm;
        logic          rm0;
        logic          rm1;
    } effect_t;

    logic                       clk_FAS;
    logic                       rst_n;
    logic                       fas_rdy_n;
    fas_opcode_e                opcode;
    layer_state_e               layer_state;
    fifo_status_t               fifo_status;
    logic [`FAS_KRNL_CNT_W-1:0] krnl_count;
    logic                       dwc_fifo_rden;
    issue_strobe_t              strobes;
    vadd_sel_t                  vadd_sel;
    logic                       vadd_rm1;
    post_sel_t                  post_sel;

    // Reference model pipes, index 0 is the issue register
    issue_strobe_t m_strb;
    vadd_sel_t     m_vsel [0:VSEL_IDX];
    post_sel_t     m_post [0:VSEL_IDX];
    logic          m_rm1  [0:RM1_IDX];

    logic [31:0]   rng;
    int            value_errs;
    int            other_errs;

    tb_clk_gen #(.PERIOD_NS (CLK_PERIOD_NS)) u_clk_gen (.clk_FAS (clk_FAS));

    fas_pip_ctrl i_dut (
        .rst_n         (rst_n),
        .clk_FAS       (clk_FAS),
        .fas_rdy_n     (fas_rdy_n),
        .opcode        (opcode),
        .layer_state   (layer_state),
        .fifo_status   (fifo_status),
        .krnl_count    (krnl_count),
        .dwc_fifo_rden (dwc_fifo_rden),
        .strobes       (strobes),
        .vadd_sel      (vadd_sel),
        .vadd_rm1      (vadd_rm1),
        .post_sel      (post_sel)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Issue table and random source
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Kept opcodes in table order
    function automatic fas_opcode_e op_at(input int idx);
        case (idx)
            0:       return op_conv_pm;
            1:       return op_conv_rm;
            2:       return op_conv_pv;
            3:       return op_conv_pm_rm_pv;
            4:       return op_pm_rm_add;
            5:       return op_resd_add;
            default: return op_part_add;
        endcase
    endfunction

    // Columns conv, part, resd, prev
    function automatic fifo_status_t required_fifos(input fas_opcode_e op);
        fifo_status_t r;
        case (op)
            op_conv_pm:       r = 4'b1110;
            op_conv_rm:       r = 4'b1000;
            op_conv_pv:       r = 4'b1001;
            op_conv_pm_rm_pv: r = 4'b1111;
            op_pm_rm_add:     r = 4'b1110;
            op_resd_add:      r = 4'b1010;
            op_part_add:      r = 4'b1100;
            default:          r = 4'b1111;
        endcase
        return r;
    endfunction

    // Strobe columns start0, start1, start2, wren1, wren2
    function automatic effect_t effect_of(input fas_opcode_e op, input logic kz);
        effect_t e;
        e = '0;
        case (op)
            op_conv_pm: begin
                e.strb = 5'b01000;
                e.pm   = kz;
            end
            op_conv_rm: e.strb = 5'b10000;
            op_conv_pv: e.strb = 5'b10000;
            op_conv_pm_rm_pv: begin
                e.strb = 5'b00100;
                e.pm   = kz;
                e.rm1  = kz;
            end
            op_pm_rm_add: begin
                e.strb = 5'b00001;
                e.pm   = 1'b1;
                e.rm1  = 1'b1;
            end
            op_resd_add: begin
                e.strb = 5'b00010;
                e.rm0  = 1'b1;
            end
            op_part_add: begin
                e.strb = 5'b00010;
                e.pm   = 1'b1;
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %0d ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic clear_model();
        m_strb = '0;
        for (int i = 0; i <= VSEL_IDX; i++) begin
            m_vsel[i] = '0;
            m_post[i] = '0;
        end
        for (int i = 0; i <= RM1_IDX; i++) begin
            m_rm1[i] = 1'b0;
        end
    endtask

    // One rising edge of the model, inputs are stable here
    task automatic model_step();
        logic    hold;
        logic    go;
        effect_t e;
        // Pipe enable seen before this edge
        hold = m_vsel[VSEL_IDX].pipe_enable;
        for (int i = VSEL_IDX; i > 0; i--) begin
            m_vsel[i] = m_vsel[i-1];
            m_post[i] = m_post[i-1];
        end
        for (int i = RM1_IDX; i > 0; i--) begin
            m_rm1[i] = m_rm1[i-1];
        end
        e  = effect_of(opcode, krnl_count == '0);
        go = !fas_rdy_n && !hold
            && (layer_state == st_active || layer_state == st_wait_last_write)
            && ((fifo_status & required_fifos(opcode)) == 4'b0000);
        if (go) begin
            m_strb    = e.strb;
            m_vsel[0] = {1'b1, e.pm, e.rm0};
            m_rm1[0]  = e.rm1;
        end else begin
            m_strb    = '0;
            m_vsel[0] = '0;
            m_rm1[0]  = 1'b0;
        end
        // Down-conversion read marks
        m_post[0].vadd_rm_conv = !fas_rdy_n && dwc_fifo_rden
            && (opcode == op_conv_pm || opcode == op_conv_rm);
        m_post[0].vadd_pv      = !fas_rdy_n && dwc_fifo_rden
            && (opcode == op_conv_pv || opcode == op_conv_pm_rm_pv);
    endtask

    task automatic compare_outputs();
        check_value("strobes", {11'd0, m_strb}, {11'd0, strobes});
        check_value("vadd_sel", {13'd0, m_vsel[VSEL_IDX]}, {13'd0, vadd_sel});
        check_value("vadd_rm1", {15'd0, m_rm1[RM1_IDX]}, {15'd0, vadd_rm1});
        check_value("post_sel", {14'd0, m_post[VSEL_IDX]}, {14'd0, post_sel});
    endtask

    // Edge for DUT and model, then compare at the falling edge
    // Callers drive new inputs right after this returns
    task automatic advance_cycle();
        @(posedge clk_FAS);
        if (!rst_n) begin
            clear_model();
        end else begin
            model_step();
        end
        @(negedge clk_FAS);
        compare_outputs();
    endtask

    task automatic check_all_low();
        check_value("strobes", 16'd0, {11'd0, strobes});
        check_value("vadd_sel", 16'd0, {13'd0, vadd_sel});
        check_value("vadd_rm1", 16'd0, {15'd0, vadd_rm1});
        check_value("post_sel", 16'd0, {14'd0, post_sel});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_and_clear();
        repeat (RST_CYCLES) advance_cycle();
        rst_n = 1'b1;
        advance_cycle();
        check_all_low();
        // Everything ready except fas_rdy_n
        fas_rdy_n     = 1'b1;
        opcode        = op_conv_pm_rm_pv;
        layer_state   = st_active;
        fifo_status   = '0;
        krnl_count    = '0;
        dwc_fifo_rden = 1'b1;
        repeat (20) begin
            advance_cycle();
            check_all_low();
        end
        fas_rdy_n     = 1'b0;
        layer_state   = st_idle;
        dwc_fifo_rden = 1'b0;
    endtask

    task automatic issue_each_opcode();
        effect_t       e;
        fas_opcode_e   op;
        logic          kz;
        issue_strobe_t exp_strb;
        vadd_sel_t     exp_vsel;
        logic          exp_rm1;
        issue_strobe_t obs_strb [OBS_LEN];
        vadd_sel_t     obs_vsel [OBS_LEN];
        logic          obs_rm1  [OBS_LEN];
        // Each opcode with kernel count zero and then non-zero
        for (int k = 0; k < 14; k++) begin
            op  = op_at(k / 2);
            kz  = ((k % 2) == 0);
            e   = effect_of(op, kz);
            rng = xorshift32(rng);
            opcode = op;
            if (kz) begin
                krnl_count = '0;
            end else begin
                krnl_count    = rng[`FAS_KRNL_CNT_W-1:0];
                krnl_count[0] = 1'b1;
            end
            fifo_status = '0;
            layer_state = st_active;
            // One sampling edge, then idle while the pipes drain
            for (int j = 0; j < OBS_LEN; j++) begin
                advance_cycle();
                obs_strb[j] = strobes;
                obs_vsel[j] = vadd_sel;
                obs_rm1[j]  = vadd_rm1;
                layer_state = st_idle;
            end
            for (int j = 0; j < OBS_LEN; j++) begin
                exp_strb = '0;
                exp_vsel = '0;
                exp_rm1  = 1'b0;
                if (j == 0) exp_strb = e.strb;
                if (j == VSEL_IDX) exp_vsel = {1'b1, e.pm, e.rm0};
                if (j == RM1_IDX) exp_rm1 = e.rm1;
                check_value("strobes", {11'd0, exp_strb}, {11'd0, obs_strb[j]});
                check_value("vadd_sel", {13'd0, exp_vsel}, {13'd0, obs_vsel[j]});
                check_value("vadd_rm1", {15'd0, exp_rm1}, {15'd0, obs_rm1[j]});
            end
        end
    endtask

    task automatic gate_on_fifo_flags();
        logic expect_issue;
        logic issued;
        for (int r = 0; r < GATE_ROUNDS; r++) begin
            rng         = xorshift32(rng);
            opcode      = op_at(int'(rng % 32'd7));
            fifo_status = rng[7:4];
            krnl_count  = rng[8 +: `FAS_KRNL_CNT_W];
            if (rng[30]) krnl_count = '0;
            // Mostly issuing states, a quarter drawn from all eight
            if (rng[3:2] == 2'b00) begin
                layer_state = layer_state_e'(rng[26:24]);
            end else if (rng[1]) begin
                layer_state = st_active;
            end else begin
                layer_state = st_wait_last_write;
            end
            expect_issue = (layer_state == st_active || layer_state == st_wait_last_write)
                && ((fifo_status & required_fifos(opcode)) == 4'b0000);
            advance_cycle();
            issued = (strobes != '0);
            check_value("issue", {15'd0, expect_issue}, {15'd0, issued});
            // Gap lets the pipe enable pass so hold-off is low next round
            layer_state = st_idle;
            repeat (GATE_GAP) advance_cycle();
        end
    endtask

    task automatic stream_with_hold_off();
        logic pe_prev;
        int   issues;
        issues      = 0;
        opcode      = op_conv_pm_rm_pv;
        fifo_status = '0;
        krnl_count  = '0;
        layer_state = st_active;
        for (int c = 0; c < STREAM_CYCLES; c++) begin
            pe_prev = vadd_sel.pipe_enable;
            advance_cycle();
            if (strobes != '0) issues++;
            // Pipe enable in the last cycle blocks this one
            if (pe_prev) begin
                check_value("strobes after pipe_enable", 16'd0, {11'd0, strobes});
            end
        end
        if (issues == 0) begin
            other_errs++;
            $display("Streaming with full FIFOs for %0d cycles gave no issue", STREAM_CYCLES);
        end
        layer_state = st_idle;
        repeat (OBS_LEN) advance_cycle();
    endtask

    task automatic pulse_dwc_reads();
        fas_opcode_e op;
        post_sel_t   exp_post;
        layer_state = st_idle;
        for (int k = 0; k < 7; k++) begin
            op                    = op_at(k);
            opcode                = op;
            exp_post.vadd_rm_conv = (op == op_conv_pm) || (op == op_conv_rm);
            exp_post.vadd_pv      = (op == op_conv_pv) || (op == op_conv_pm_rm_pv);
            dwc_fifo_rden         = 1'b1;
            for (int j = 0; j < POST_LEN; j++) begin
                advance_cycle();
                dwc_fifo_rden = 1'b0;
                if (j == VSEL_IDX) begin
                    check_value("post_sel", {14'd0, exp_post}, {14'd0, post_sel});
                end else begin
                    check_value("post_sel", 16'd0, {14'd0, post_sel});
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rng           = 32'h8e37;
        value_errs    = 0;
        other_errs    = 0;
        rst_n         = 1'b0;
        fas_rdy_n     = 1'b1;
        opcode        = op_conv_pm;
        layer_state   = st_idle;
        fifo_status   = '1;
        krnl_count    = '0;
        dwc_fifo_rden = 1'b0;
        clear_model();
        reset_and_clear();
        issue_each_opcode();
        gate_on_fifo_flags();
        stream_with_hold_off();
        pulse_dwc_reads();
        $display("Summary: %0d value mismatches and %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Stops a stuck run
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule
